// File: logic/mips_defines.svh
`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

// Boot ROM entry point, first fetch after reset
`define MIPS_RESET_VECTOR 32'hBFC0_0000

// Architectural register count
`define MIPS_REG_COUNT 32

// Return value register, exported for observation
`define MIPS_V0_INDEX 5'd2

// Link register written by JAL
`define MIPS_RA_INDEX 5'd31

`endif

// File: logic/mips_pkg.sv
`default_nettype none

package mips_pkg;

  // Data and address word
  typedef logic [31:0] word_t;

  // Register file index
  typedef logic [4:0] reg_idx_t;

  // Primary opcodes, bits 31:26
  typedef enum logic [5:0] {
    OP_SPECIAL = 6'h00,
    OP_J       = 6'h02,
    OP_JAL     = 6'h03,
    OP_BEQ     = 6'h04,
    OP_BNE     = 6'h05,
    OP_ADDIU   = 6'h09,
    OP_ANDI    = 6'h0c,
    OP_ORI     = 6'h0d,
    OP_LUI     = 6'h0f,
    OP_LW      = 6'h23,
    OP_SW      = 6'h2b
  } opcode_t;

  // R-type function codes, bits 5:0
  typedef enum logic [5:0] {
    FN_SLL  = 6'h00,
    FN_JR   = 6'h08,
    FN_ADDU = 6'h21,
    FN_SUBU = 6'h23,
    FN_AND  = 6'h24,
    FN_OR   = 6'h25,
    FN_XOR  = 6'h26,
    FN_SLT  = 6'h2a
  } funct_t;

  // ALU operations
  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLL,
    ALU_LUI
  } alu_op_t;

  // Write-back source
  typedef enum logic [1:0] {
    WB_ALU = 2'd0,
    WB_MEM = 2'd1,
    WB_PC8 = 2'd2
  } wb_sel_t;

  // Redirect kind
  typedef enum logic [1:0] {
    PC_SEQ    = 2'd0,
    PC_BRANCH = 2'd1,
    PC_JUMP   = 2'd2,
    PC_JR     = 2'd3
  } pc_sel_t;

endpackage

`default_nettype wire

// File: logic/mips_control.sv
`default_nettype none

module mips_control (
  input  mips_pkg::opcode_t opcode,
  input  mips_pkg::funct_t  funct,
  output mips_pkg::alu_op_t alu_op,
  output logic              alu_src_imm,
  output logic              imm_zero_ext,
  output logic              reg_dst_rd,
  output logic              link,
  output logic              reg_write,
  output logic              mem_read,
  output logic              mem_write,
  output mips_pkg::wb_sel_t wb_sel,
  output mips_pkg::pc_sel_t pc_sel,
  output logic              branch_ne
);

  always_comb
  begin
    // Safe defaults, unknown encodings fall through as a no-op
    alu_op       = mips_pkg::ALU_ADD;
    alu_src_imm  = 1'b0;
    imm_zero_ext = 1'b0;
    reg_dst_rd   = 1'b0;
    link         = 1'b0;
    reg_write    = 1'b0;
    mem_read     = 1'b0;
    mem_write    = 1'b0;
    wb_sel       = mips_pkg::WB_ALU;
    pc_sel       = mips_pkg::PC_SEQ;
    branch_ne    = 1'b0;

    case (opcode)
      mips_pkg::OP_SPECIAL:
      begin
        // R-type writes rd unless the funct is unknown or JR
        reg_dst_rd = 1'b1;
        reg_write  = 1'b1;
        case (funct)
          mips_pkg::FN_ADDU: alu_op = mips_pkg::ALU_ADD;
          mips_pkg::FN_SUBU: alu_op = mips_pkg::ALU_SUB;
          mips_pkg::FN_AND:  alu_op = mips_pkg::ALU_AND;
          mips_pkg::FN_OR:   alu_op = mips_pkg::ALU_OR;
          mips_pkg::FN_XOR:  alu_op = mips_pkg::ALU_XOR;
          mips_pkg::FN_SLT:  alu_op = mips_pkg::ALU_SLT;
          mips_pkg::FN_SLL:  alu_op = mips_pkg::ALU_SLL;
          mips_pkg::FN_JR:
          begin
            reg_write = 1'b0;
            pc_sel    = mips_pkg::PC_JR;
          end
          default:           reg_write = 1'b0;
        endcase
      end
      mips_pkg::OP_ADDIU:
      begin
        alu_src_imm = 1'b1;
        reg_write   = 1'b1;
      end
      mips_pkg::OP_ANDI:
      begin
        alu_op       = mips_pkg::ALU_AND;
        alu_src_imm  = 1'b1;
        imm_zero_ext = 1'b1;
        reg_write    = 1'b1;
      end
      mips_pkg::OP_ORI:
      begin
        alu_op       = mips_pkg::ALU_OR;
        alu_src_imm  = 1'b1;
        imm_zero_ext = 1'b1;
        reg_write    = 1'b1;
      end
      mips_pkg::OP_LUI:
      begin
        alu_op      = mips_pkg::ALU_LUI;
        alu_src_imm = 1'b1;
        reg_write   = 1'b1;
      end
      mips_pkg::OP_LW:
      begin
        // Address is base plus signed offset
        alu_src_imm = 1'b1;
        mem_read    = 1'b1;
        reg_write   = 1'b1;
        wb_sel      = mips_pkg::WB_MEM;
      end
      mips_pkg::OP_SW:
      begin
        alu_src_imm = 1'b1;
        mem_write   = 1'b1;
      end
      mips_pkg::OP_BEQ: pc_sel = mips_pkg::PC_BRANCH;
      mips_pkg::OP_BNE:
      begin
        pc_sel    = mips_pkg::PC_BRANCH;
        branch_ne = 1'b1;
      end
      mips_pkg::OP_J:   pc_sel = mips_pkg::PC_JUMP;
      mips_pkg::OP_JAL:
      begin
        // Link address goes to ra
        pc_sel    = mips_pkg::PC_JUMP;
        link      = 1'b1;
        reg_write = 1'b1;
        wb_sel    = mips_pkg::WB_PC8;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// File: logic/mips_regfile.sv
`default_nettype none

`include "mips_defines.svh"

module mips_regfile (
  input  logic               clk,
  input  logic               reset,
  input  logic               enable,
  input  mips_pkg::reg_idx_t read_idx_a,
  input  mips_pkg::reg_idx_t read_idx_b,
  input  mips_pkg::reg_idx_t write_idx,
  input  logic               write_en,
  input  mips_pkg::word_t    write_data,
  output mips_pkg::word_t    read_data_a,
  output mips_pkg::word_t    read_data_b,
  output mips_pkg::word_t    register_v0
);

  mips_pkg::word_t regs [`MIPS_REG_COUNT];

  // Register 0 is zero only because it is cleared and never written
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      for (int i = 0; i < `MIPS_REG_COUNT; i++)
      begin
        regs[i] <= '0;
      end
    end
    else if (enable && write_en && (write_idx != '0))
    begin
      regs[write_idx] <= write_data;
    end
  end

  // Combinational reads, same-cycle operands
  assign read_data_a = regs[read_idx_a];
  assign read_data_b = regs[read_idx_b];

  // v0 exported for the test harness
  assign register_v0 = regs[`MIPS_V0_INDEX];

  // r0 holds zero across every write that reaches this block
  a_r0_zero: assert property (
    @(posedge clk) disable iff (reset)
    (read_idx_a == '0) |-> (read_data_a == '0)
  );

endmodule

`default_nettype wire

// File: logic/mips_alu.sv
`default_nettype none

module mips_alu (
  input  mips_pkg::alu_op_t alu_op,
  input  mips_pkg::word_t   operand_a,
  input  mips_pkg::word_t   operand_b,
  input  logic [4:0]        shamt,
  output mips_pkg::word_t   result,
  output logic              equal
);

  // Signed views for SLT
  logic signed [31:0] signed_a;
  logic signed [31:0] signed_b;

  assign signed_a = operand_a;
  assign signed_b = operand_b;

  always_comb
  begin
    case (alu_op)
      // Unsigned add and subtract, wrap without trap
      mips_pkg::ALU_ADD: result = operand_a + operand_b;
      mips_pkg::ALU_SUB: result = operand_a - operand_b;
      mips_pkg::ALU_AND: result = operand_a & operand_b;
      mips_pkg::ALU_OR:  result = operand_a | operand_b;
      mips_pkg::ALU_XOR: result = operand_a ^ operand_b;
      mips_pkg::ALU_SLT:
      begin
        result = {31'b0, (signed_a < signed_b)};
      end
      // Shift source is rt, amount from the instruction
      mips_pkg::ALU_SLL: result = operand_b << shamt;
      // Immediate into the upper half
      mips_pkg::ALU_LUI: result = operand_b << 16;
      default:           result = '0;
    endcase
  end

  // Branch compare, rs against rt
  assign equal = (operand_a == operand_b);

endmodule

`default_nettype wire

// File: logic/mips_next_pc.sv
`default_nettype none

`include "mips_defines.svh"

module mips_next_pc (
  input  logic              clk,
  input  logic              reset,
  input  logic              enable,
  input  mips_pkg::pc_sel_t pc_sel,
  input  logic              branch_taken,
  input  logic [15:0]       imm,
  input  logic [25:0]       jump_index,
  input  mips_pkg::word_t   rs_value,
  output mips_pkg::word_t   pc,
  output mips_pkg::word_t   pc_plus8
);

  mips_pkg::word_t pc_plus4;
  mips_pkg::word_t branch_target;
  mips_pkg::word_t jump_target;
  mips_pkg::word_t target;
  mips_pkg::word_t pending_target;
  logic            redirect;
  logic            pending;

  assign pc_plus4 = pc + 32'd4;
  assign pc_plus8 = pc + 32'd8;

  // Offset relative to the delay slot
  assign branch_target = pc_plus4 + {{14{imm[15]}}, imm, 2'b00};
  // Region bits come from the delay slot address
  assign jump_target = {pc_plus4[31:28], jump_index, 2'b00};

  always_comb
  begin
    redirect = 1'b1;
    target   = jump_target;
    case (pc_sel)
      mips_pkg::PC_BRANCH:
      begin
        redirect = branch_taken;
        target   = branch_target;
      end
      mips_pkg::PC_JUMP: target = jump_target;
      mips_pkg::PC_JR:   target = rs_value;
      default:           redirect = 1'b0;
    endcase
  end

  // Redirect takes effect one instruction late
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      pc      <= `MIPS_RESET_VECTOR;
      pending <= 1'b0;
    end
    else if (enable)
    begin
      pc      <= pending ? pending_target : pc_plus4;
      pending <= redirect;
    end
  end

  always_ff @(posedge clk)
  begin
    if (enable)
    begin
      pending_target <= target;
    end
  end

  // Parked target must be a legal fetch address
  a_target_aligned: assert property (
    @(posedge clk) disable iff (reset)
    pending |-> (pending_target[1:0] == 2'b00)
  );

endmodule

`default_nettype wire

// File: logic/mips_cpu_harvard.sv
`default_nettype none

`include "mips_defines.svh"

module mips_cpu_harvard (
  input  logic            clk,
  input  logic            reset,
  output logic            active,
  output mips_pkg::word_t register_v0,
  input  logic            clk_enable,
  output mips_pkg::word_t instr_address,
  input  mips_pkg::word_t instr_readdata,
  output mips_pkg::word_t data_address,
  output logic            data_write,
  output logic            data_read,
  output mips_pkg::word_t data_writedata,
  input  mips_pkg::word_t data_readdata
);

  // Instruction fields
  mips_pkg::opcode_t  opcode;
  mips_pkg::funct_t   funct;
  mips_pkg::reg_idx_t rs;
  mips_pkg::reg_idx_t rt;
  mips_pkg::reg_idx_t rd;
  logic [4:0]         shamt;
  logic [15:0]        imm;
  logic [25:0]        jump_index;

  assign opcode     = mips_pkg::opcode_t'(instr_readdata[31:26]);
  assign funct      = mips_pkg::funct_t'(instr_readdata[5:0]);
  assign rs         = instr_readdata[25:21];
  assign rt         = instr_readdata[20:16];
  assign rd         = instr_readdata[15:11];
  assign shamt      = instr_readdata[10:6];
  assign imm        = instr_readdata[15:0];
  assign jump_index = instr_readdata[25:0];

  // Decode outputs
  mips_pkg::alu_op_t alu_op;
  mips_pkg::wb_sel_t wb_sel;
  mips_pkg::pc_sel_t pc_sel;
  logic              alu_src_imm;
  logic              imm_zero_ext;
  logic              reg_dst_rd;
  logic              link;
  logic              reg_write;
  logic              mem_read;
  logic              mem_write;
  logic              branch_ne;

  // Datapath
  mips_pkg::word_t    rs_value;
  mips_pkg::word_t    rt_value;
  mips_pkg::word_t    imm_ext;
  mips_pkg::word_t    operand_b;
  mips_pkg::word_t    alu_result;
  mips_pkg::word_t    pc_plus8;
  mips_pkg::word_t    wb_data;
  mips_pkg::reg_idx_t write_idx;
  logic               equal;
  logic               branch_taken;
  logic               halted;
  logic               running;
  logic               step;

  // Fetch from address zero means the program has finished
  assign halted  = (instr_address == '0);
  assign running = active && !halted;
  // One commit per enabled edge while running
  assign step    = clk_enable && running;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      active <= 1'b1;
    end
    else if (clk_enable && halted)
    begin
      active <= 1'b0;
    end
  end

  mips_control u_mips_control (
    .opcode       (opcode),
    .funct        (funct),
    .alu_op       (alu_op),
    .alu_src_imm  (alu_src_imm),
    .imm_zero_ext (imm_zero_ext),
    .reg_dst_rd   (reg_dst_rd),
    .link         (link),
    .reg_write    (reg_write),
    .mem_read     (mem_read),
    .mem_write    (mem_write),
    .wb_sel       (wb_sel),
    .pc_sel       (pc_sel),
    .branch_ne    (branch_ne)
  );

  // JAL links into ra, R-type into rd, the rest into rt
  assign write_idx = link       ? `MIPS_RA_INDEX :
                     reg_dst_rd ? rd             : rt;

  always_comb
  begin
    case (wb_sel)
      mips_pkg::WB_MEM: wb_data = data_readdata;
      mips_pkg::WB_PC8: wb_data = pc_plus8;
      default:          wb_data = alu_result;
    endcase
  end

  mips_regfile u_mips_regfile (
    .clk         (clk),
    .reset       (reset),
    .enable      (step),
    .read_idx_a  (rs),
    .read_idx_b  (rt),
    .write_idx   (write_idx),
    .write_en    (reg_write),
    .write_data  (wb_data),
    .read_data_a (rs_value),
    .read_data_b (rt_value),
    .register_v0 (register_v0)
  );

  // Logical immediates are zero extended
  assign imm_ext   = imm_zero_ext ? {16'b0, imm} : {{16{imm[15]}}, imm};
  assign operand_b = alu_src_imm ? imm_ext : rt_value;

  mips_alu u_mips_alu (
    .alu_op    (alu_op),
    .operand_a (rs_value),
    .operand_b (operand_b),
    .shamt     (shamt),
    .result    (alu_result),
    .equal     (equal)
  );

  // BNE inverts the compare
  assign branch_taken = branch_ne ? !equal : equal;

  mips_next_pc u_mips_next_pc (
    .clk          (clk),
    .reset        (reset),
    .enable       (step),
    .pc_sel       (pc_sel),
    .branch_taken (branch_taken),
    .imm          (imm),
    .jump_index   (jump_index),
    .rs_value     (rs_value),
    .pc           (instr_address),
    .pc_plus8     (pc_plus8)
  );

  // Memory port, strobes quiet once halted
  assign data_address   = alu_result;
  assign data_writedata = rt_value;
  assign data_read      = mem_read && running;
  assign data_write     = mem_write && running;

endmodule

`default_nettype wire

// File: verification/mips_tb_clock.sv
`default_nettype none

module mips_tb_clock #(
  parameter int PERIOD = 100
) (
  output logic clk
);

  // Free running, low at time zero
  initial
  begin
    clk = 1'b0;
  end

  always #(PERIOD / 2) clk = ~clk;

endmodule

`default_nettype wire

// File: verification/mips_tb_memory.sv
`default_nettype none

`include "mips_defines.svh"

module mips_tb_memory (
  input  logic            clk,
  input  logic            clk_enable,
  input  logic            clear,
  input  logic            load_en,
  input  logic [5:0]      load_index,
  input  mips_pkg::word_t load_word,
  input  logic [5:0]      peek_index,
  output mips_pkg::word_t peek_word,
  input  mips_pkg::word_t instr_address,
  output mips_pkg::word_t instr_readdata,
  input  mips_pkg::word_t data_address,
  input  logic            data_write,
  input  logic            data_read,
  input  mips_pkg::word_t data_writedata,
  output mips_pkg::word_t data_readdata
);

  // Program window at the reset vector, data window from address zero
  mips_pkg::word_t rom [64];
  mips_pkg::word_t ram [64];
  mips_pkg::word_t rom_offset;

  assign rom_offset = instr_address - `MIPS_RESET_VECTOR;

  // Only offset bits 7:2 decode, so address zero aliases slot 0
  assign instr_readdata = rom[rom_offset[7:2]];
  assign data_readdata  = data_read ? ram[data_address[7:2]] : '0;
  assign peek_word      = ram[peek_index];

  always_ff @(posedge clk)
  begin
    if (clear)
    begin
      for (int i = 0; i < 64; i++)
      begin
        rom[i] <= '0;
        ram[i] <= '0;
      end
    end
    else
    begin
      if (load_en)
      begin
        rom[load_index] <= load_word;
      end
      // Stores land only on enabled edges
      if (clk_enable && data_write)
      begin
        ram[data_address[7:2]] <= data_writedata;
      end
    end
  end

endmodule

`default_nettype wire

// File: verification/mips_cpu_tb.sv
`default_nettype none

`include "mips_defines.svh"

module mips_cpu_tb;

  logic            clk;
  logic            reset;
  logic            clk_enable;
  logic            active;
  mips_pkg::word_t register_v0;
  mips_pkg::word_t instr_address;
  mips_pkg::word_t instr_readdata;
  mips_pkg::word_t data_address;
  logic            data_write;
  logic            data_read;
  mips_pkg::word_t data_writedata;
  mips_pkg::word_t data_readdata;

  // Loader and inspection side of the memory model
  logic            mem_clear;
  logic            load_en;
  logic [5:0]      load_index;
  mips_pkg::word_t load_word;
  logic [5:0]      peek_index;
  mips_pkg::word_t peek_word;

  mips_pkg::word_t program_words [$];
  integer          seed;
  int              error_count;
  int              check_count;
  int              cycle_count = 0;
  int              cycle_limit = 0;

  mips_tb_clock u_mips_tb_clock (
    .clk (clk)
  );

  mips_tb_memory u_mips_tb_memory (
    .clk            (clk),
    .clk_enable     (clk_enable),
    .clear          (mem_clear),
    .load_en        (load_en),
    .load_index     (load_index),
    .load_word      (load_word),
    .peek_index     (peek_index),
    .peek_word      (peek_word),
    .instr_address  (instr_address),
    .instr_readdata (instr_readdata),
    .data_address   (data_address),
    .data_write     (data_write),
    .data_read      (data_read),
    .data_writedata (data_writedata),
    .data_readdata  (data_readdata)
  );

  mips_cpu_harvard u_mips_cpu_harvard (
    .clk            (clk),
    .reset          (reset),
    .active         (active),
    .register_v0    (register_v0),
    .clk_enable     (clk_enable),
    .instr_address  (instr_address),
    .instr_readdata (instr_readdata),
    .data_address   (data_address),
    .data_write     (data_write),
    .data_read      (data_read),
    .data_writedata (data_writedata),
    .data_readdata  (data_readdata)
  );

  // Executed cycles only, loading and stalls are not counted
  always @(posedge clk)
  begin
    if (!reset && clk_enable)
    begin
      cycle_count = cycle_count + 1;
    end
    if (cycle_count > cycle_limit)
    begin
      $display("Timeout: %0d executed cycles without a halt, limit %0d", cycle_count, cycle_limit);
      $display("Finished with errors");
      $finish;
    end
  end

  // Inputs change 10 units after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #10;
  endtask

  task automatic check_word(input string name, input mips_pkg::word_t expected,
                            input mips_pkg::word_t actual);
    check_count++;
    if (actual !== expected)
    begin
      error_count++;
      $display("FAIL %0t %s expected %08h actual %08h", $time, name, expected, actual);
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    check_count++;
    if (actual !== expected)
    begin
      error_count++;
      $display("FAIL %0t %s expected %0b actual %0b", $time, name, expected, actual);
    end
  endtask

  task automatic check_ram(input mips_pkg::word_t address, input mips_pkg::word_t expected);
    peek_index = address[7:2];
    #1;
    check_word($sformatf("data memory %08h", address), expected, peek_word);
  endtask

  // Instruction encoders
  function automatic mips_pkg::word_t encode_r(input mips_pkg::funct_t fn,
                                               input mips_pkg::reg_idx_t rs,
                                               input mips_pkg::reg_idx_t rt,
                                               input mips_pkg::reg_idx_t rd,
                                               input logic [4:0] sa);
    return {mips_pkg::OP_SPECIAL, rs, rt, rd, sa, fn};
  endfunction

  function automatic mips_pkg::word_t encode_i(input mips_pkg::opcode_t op,
                                               input mips_pkg::reg_idx_t rs,
                                               input mips_pkg::reg_idx_t rt,
                                               input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic mips_pkg::word_t encode_j(input mips_pkg::opcode_t op,
                                               input mips_pkg::word_t target);
    return {op, target[27:2]};
  endfunction

  // Byte address of a program slot
  function automatic mips_pkg::word_t slot_address(input int index);
    return `MIPS_RESET_VECTOR + (mips_pkg::word_t'(index) << 2);
  endfunction

  // Reference results from the ISA rules
  function automatic mips_pkg::word_t reference_reg(input mips_pkg::funct_t fn,
                                                    input mips_pkg::word_t a,
                                                    input mips_pkg::word_t b,
                                                    input logic [4:0] sa);
    case (fn)
      mips_pkg::FN_ADDU: return a + b;
      mips_pkg::FN_SUBU: return a - b;
      mips_pkg::FN_AND:  return a & b;
      mips_pkg::FN_OR:   return a | b;
      mips_pkg::FN_XOR:  return a ^ b;
      mips_pkg::FN_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      mips_pkg::FN_SLL:  return b << sa;
      default:           return '0;
    endcase
  endfunction

  function automatic mips_pkg::word_t reference_imm(input mips_pkg::opcode_t op,
                                                    input mips_pkg::word_t a,
                                                    input logic [15:0] imm);
    case (op)
      mips_pkg::OP_ADDIU: return a + {{16{imm[15]}}, imm};
      mips_pkg::OP_ANDI:  return a & {16'h0000, imm};
      mips_pkg::OP_ORI:   return a | {16'h0000, imm};
      mips_pkg::OP_LUI:   return {imm, 16'h0000};
      default:            return '0;
    endcase
  endfunction

  task automatic emit(input mips_pkg::word_t word);
    program_words.push_back(word);
  endtask

  // Full 32-bit constant in two instructions
  task automatic emit_const(input mips_pkg::reg_idx_t r, input mips_pkg::word_t value);
    emit(encode_i(mips_pkg::OP_LUI, 5'd0, r, value[31:16]));
    emit(encode_i(mips_pkg::OP_ORI, r, r, value[15:0]));
  endtask

  // JR to address zero plus its delay slot
  task automatic emit_halt();
    emit(encode_r(mips_pkg::FN_JR, 5'd0, 5'd0, 5'd0, 5'd0));
    emit(32'h0000_0000);
  endtask

  // ROM slot 0 is also what the halted core fetches from address zero
  task automatic load_halt_fetch(input mips_pkg::word_t word);
    load_en    = 1'b1;
    load_index = '0;
    load_word  = word;
    next_cycle();
    load_en = 1'b0;
  endtask

  // Load with the core stalled, reset, run to halt
  task automatic run_program(input int stall_at, input int stall_len);
    int              cycle;
    logic            halting;
    mips_pkg::word_t held_pc;
    mips_pkg::word_t held_v0;
    clk_enable = 1'b0;
    mem_clear  = 1'b1;
    next_cycle();
    mem_clear = 1'b0;
    foreach (program_words[i])
    begin
      load_en    = 1'b1;
      load_index = 6'(i);
      load_word  = program_words[i];
      next_cycle();
    end
    load_en = 1'b0;
    reset   = 1'b1;
    repeat (3) next_cycle();
    reset       = 1'b0;
    clk_enable  = 1'b1;
    cycle_limit = cycle_limit + 2 * program_words.size();
    check_word("instr_address", `MIPS_RESET_VECTOR, instr_address);
    check_flag("active", 1'b1, active);
    check_word("register_v0", '0, register_v0);
    cycle = 0;
    while (active)
    begin
      halting = (instr_address == '0);
      if (cycle == stall_at && stall_len > 0)
      begin
        held_pc    = instr_address;
        held_v0    = register_v0;
        clk_enable = 1'b0;
        repeat (stall_len)
        begin
          next_cycle();
          check_word("instr_address", held_pc, instr_address);
          check_word("register_v0", held_v0, register_v0);
          check_flag("active", 1'b1, active);
        end
        clk_enable = 1'b1;
      end
      next_cycle();
      cycle++;
      // Halt takes exactly one edge once PC is zero
      if (halting)
      begin
        check_flag("active", 1'b0, active);
      end
    end
  endtask

  task automatic test_alu_reg(input mips_pkg::funct_t fn);
    mips_pkg::word_t a;
    mips_pkg::word_t b;
    logic [4:0]      sa;
    a  = $random(seed);
    b  = $random(seed);
    sa = 5'($random(seed));
    program_words.delete();
    emit_const(5'd8, a);
    emit_const(5'd9, b);
    if (fn == mips_pkg::FN_SLL)
    begin
      emit(encode_r(fn, 5'd0, 5'd9, 5'd10, sa));
    end
    else
    begin
      emit(encode_r(fn, 5'd8, 5'd9, 5'd10, 5'd0));
    end
    // Result copied into v0
    emit(encode_r(mips_pkg::FN_ADDU, 5'd10, 5'd0, 5'd2, 5'd0));
    emit_halt();
    run_program(0, 0);
    check_word({"register_v0 ", fn.name()}, reference_reg(fn, a, b, sa), register_v0);
  endtask

  task automatic test_alu_imm(input mips_pkg::opcode_t op);
    mips_pkg::word_t a;
    logic [15:0]     imm;
    a   = $random(seed);
    imm = 16'($random(seed));
    program_words.delete();
    emit_const(5'd8, a);
    emit(encode_i(op, 5'd8, 5'd10, imm));
    emit(encode_r(mips_pkg::FN_ADDU, 5'd10, 5'd0, 5'd2, 5'd0));
    emit_halt();
    run_program(0, 0);
    check_word({"register_v0 ", op.name()}, reference_imm(op, a, imm), register_v0);
  endtask

  task automatic test_load_store();
    mips_pkg::word_t a;
    mips_pkg::word_t b;
    a = $random(seed);
    b = $random(seed);
    program_words.delete();
    // Base 0x40, positive and negative offsets
    emit(encode_i(mips_pkg::OP_ADDIU, 5'd0, 5'd8, 16'h0040));
    emit_const(5'd9, a);
    emit_const(5'd11, b);
    emit(encode_i(mips_pkg::OP_SW, 5'd8, 5'd9, 16'h0004));
    emit(encode_i(mips_pkg::OP_SW, 5'd8, 5'd11, 16'hFFF8));
    // Both writes to r0 must vanish
    emit(encode_i(mips_pkg::OP_ADDIU, 5'd0, 5'd0, 16'h1234));
    emit(encode_i(mips_pkg::OP_LW, 5'd8, 5'd0, 16'h0004));
    emit(encode_i(mips_pkg::OP_LW, 5'd8, 5'd10, 16'h0004));
    emit(encode_i(mips_pkg::OP_LW, 5'd8, 5'd12, 16'hFFF8));
    emit(encode_r(mips_pkg::FN_ADDU, 5'd10, 5'd12, 5'd2, 5'd0));
    emit(encode_r(mips_pkg::FN_ADDU, 5'd2, 5'd0, 5'd2, 5'd0));
    emit(encode_i(mips_pkg::OP_SW, 5'd8, 5'd2, 16'h0000));
    emit_halt();
    run_program(0, 0);
    check_word("register_v0", a + b, register_v0);
    check_ram(32'h0000_0044, a);
    check_ram(32'h0000_0038, b);
    check_ram(32'h0000_0040, a + b);
  endtask

  // r8 = r9 = 5, r10 = 7; v0 sums the addends that must run
  task automatic build_branch_program(output mips_pkg::word_t expected);
    program_words.delete();
    expected = '0;
    emit(encode_i(mips_pkg::OP_ADDIU, 5'd0, 5'd8, 16'd5));
    emit(encode_i(mips_pkg::OP_ADDIU, 5'd0, 5'd9, 16'd5));
    emit(encode_i(mips_pkg::OP_ADDIU, 5'd0, 5'd10, 16'd7));
    // BEQ taken, slot 5 skipped
    emit(encode_i(mips_pkg::OP_BEQ, 5'd8, 5'd9, 16'd2));
    emit(encode_i(mips_pkg::OP_ADDIU, 5'd2, 5'd2, 16'd1));
    expected = expected + 32'd1;
    emit(encode_i(mips_pkg::OP_ADDIU, 5'd2, 5'd2, 16'd100));
    // BNE not taken, falls through
    emit(encode_i(mips_pkg::OP_BNE, 5'd8, 5'd9, 16'd2));
    emit(encode_i(mips_pkg::OP_ADDIU, 5'd2, 5'd2, 16'd2));
    expected = expected + 32'd2;
    emit(encode_i(mips_pkg::OP_ADDIU, 5'd2, 5'd2, 16'd4));
    expected = expected + 32'd4;
    // BEQ not taken
    emit(encode_i(mips_pkg::OP_BEQ, 5'd8, 5'd10, 16'd2));
    emit(encode_i(mips_pkg::OP_ADDIU, 5'd2, 5'd2, 16'd8));
    expected = expected + 32'd8;
    emit(encode_i(mips_pkg::OP_ADDIU, 5'd2, 5'd2, 16'd16));
    expected = expected + 32'd16;
    // BNE taken, slot 14 skipped
    emit(encode_i(mips_pkg::OP_BNE, 5'd8, 5'd10, 16'd2));
    emit(encode_i(mips_pkg::OP_ADDIU, 5'd2, 5'd2, 16'd32));
    expected = expected + 32'd32;
    emit(encode_i(mips_pkg::OP_ADDIU, 5'd2, 5'd2, 16'd200));
    emit_halt();
  endtask

  task automatic test_branches();
    mips_pkg::word_t expected;
    build_branch_program(expected);
    run_program(0, 0);
    check_word("register_v0", expected, register_v0);
  endtask

  task automatic test_jumps();
    program_words.delete();
    emit(encode_j(mips_pkg::OP_J, slot_address(3)));
    emit(encode_i(mips_pkg::OP_ADDIU, 5'd0, 5'd2, 16'd1));
    emit(encode_i(mips_pkg::OP_ADDIU, 5'd2, 5'd2, 16'd100));
    emit(encode_j(mips_pkg::OP_JAL, slot_address(6)));
    emit(encode_i(mips_pkg::OP_ADDIU, 5'd2, 5'd2, 16'd2));
    emit(encode_i(mips_pkg::OP_ADDIU, 5'd2, 5'd2, 16'd200));
    // Delay-slot sum parked in memory, then ra into v0
    emit(encode_i(mips_pkg::OP_SW, 5'd0, 5'd2, 16'h0040));
    emit(encode_r(mips_pkg::FN_ADDU, 5'd31, 5'd0, 5'd2, 5'd0));
    emit_halt();
    run_program(0, 0);
    check_ram(32'h0000_0040, 32'd3);
    check_word("register_v0", slot_address(3) + 32'd8, register_v0);
  endtask

  task automatic test_halt_stall();
    mips_pkg::word_t expected;
    int              stall_at;
    int              stall_len;
    stall_at  = ($random(seed) & 7) + 2;
    stall_len = ($random(seed) & 15) + 1;
    build_branch_program(expected);
    run_program(stall_at, stall_len);
    // Same sum as the unstalled branch run
    check_word("register_v0", expected, register_v0);
    // Halted core fetches a store, which must stay quiet
    load_halt_fetch(encode_i(mips_pkg::OP_SW, 5'd0, 5'd2, 16'h0040));
    repeat (2)
    begin
      next_cycle();
      check_flag("active", 1'b0, active);
      check_word("instr_address", '0, instr_address);
      check_flag("data_write", 1'b0, data_write);
    end
    check_ram(32'h0000_0040, '0);
    // Then a load, no read strobe and no write-back
    load_halt_fetch(encode_i(mips_pkg::OP_LW, 5'd0, 5'd2, 16'h0040));
    repeat (2)
    begin
      next_cycle();
      check_flag("active", 1'b0, active);
      check_word("instr_address", '0, instr_address);
      check_flag("data_read", 1'b0, data_read);
      check_word("register_v0", expected, register_v0);
    end
  endtask

  initial
  begin
    seed        = 34529;
    error_count = 0;
    check_count = 0;
    reset       = 1'b1;
    clk_enable  = 1'b0;
    mem_clear   = 1'b0;
    load_en     = 1'b0;
    load_index  = '0;
    load_word   = '0;
    peek_index  = '0;
    repeat (3) next_cycle();
    reset = 1'b0;

    test_alu_reg(mips_pkg::FN_ADDU);
    test_alu_reg(mips_pkg::FN_SUBU);
    test_alu_reg(mips_pkg::FN_AND);
    test_alu_reg(mips_pkg::FN_OR);
    test_alu_reg(mips_pkg::FN_XOR);
    test_alu_reg(mips_pkg::FN_SLT);
    test_alu_reg(mips_pkg::FN_SLL);
    test_alu_imm(mips_pkg::OP_ADDIU);
    test_alu_imm(mips_pkg::OP_ANDI);
    test_alu_imm(mips_pkg::OP_ORI);
    test_alu_imm(mips_pkg::OP_LUI);
    test_load_store();
    test_branches();
    test_jumps();
    test_halt_stall();

    $display("Checks run: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0)
    begin
      $display("Finished with no errors");
    end
    else
    begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
+incdir+logic
logic/mips_pkg.sv
logic/mips_control.sv
logic/mips_regfile.sv
logic/mips_alu.sv
logic/mips_next_pc.sv
logic/mips_cpu_harvard.sv
verification/mips_tb_clock.sv
verification/mips_tb_memory.sv
verification/mips_cpu_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the MIPS core testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f project.f \
  --top-module mips_cpu_tb \
  -o mips_cpu_sim

./obj_dir/mips_cpu_sim > sim.log 2>&1
cat sim.log

# The testbench reports the verdict in the log
if grep -q "Finished with errors" sim.log; then
  exit 1
fi
exit 0
